//--- hdl/fpslice_pkg.sv
/*
 * Shared sizes, types and constants of the FP non-computational slice.
 * It holds the lane count, pipeline depth, formats and operations.
 */
`default_nettype none

package fpslice_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int unsigned WORD_BITS   = 32;
  localparam int unsigned HALF_BITS   = 16; // One FP16 slice
  localparam int unsigned NUM_LANES   = 2;
  localparam int unsigned PIPE_STAGES = 2;  // Register stages per lane
  localparam int unsigned TAG_BITS    = 4;
  localparam int unsigned STATUS_BITS = 5;

  // Mantissa widths of the two formats
  localparam int unsigned MAN_S_BITS = 23;
  localparam int unsigned MAN_H_BITS = 10;

  // Position of the invalid flag, order is NV DZ OF UF NX
  localparam int unsigned NV_BIT = 4;

  // ------------------------------
  // Types
  // ------------------------------
  typedef logic [WORD_BITS-1:0]   word_t;
  typedef logic [TAG_BITS-1:0]    tag_t;
  typedef logic [STATUS_BITS-1:0] status_t;
  typedef logic [NUM_LANES-1:0]   lane_mask_t;

  typedef enum logic {
    FMT_FP32,
    FMT_FP16
  } fp_fmt_e;

  typedef enum logic [2:0] {
    OP_MIN,
    OP_MAX,
    OP_SGNJ,
    OP_SGNJN,
    OP_SGNJX
  } slice_op_e;

  // Canonical quiet NaNs
  localparam word_t CANON_NAN_H = 32'h0000_7e00;
  localparam word_t CANON_NAN_S = 32'h7fc0_0000;

endpackage

`default_nettype wire

//--- hdl/fp_sgnj_minmax.sv
/*
 * Lane datapath for MIN/MAX and sign injection in FP32 or FP16.
 * Purely combinational, only NV is ever raised.
 */
`default_nettype none

module fp_sgnj_minmax
  import fpslice_pkg::*;
(
  input  word_t     op_a_i,
  input  word_t     op_b_i,
  input  slice_op_e op_i,
  input  fp_fmt_e   fmt_i,
  output word_t     result_o,
  output status_t   status_o
);

  logic  sign_a, sign_b;
  logic  nan_a, nan_b;
  logic  snan_a, snan_b;
  logic  zero_a, zero_b;
  word_t mag_a, mag_b;   // Magnitude without sign, zero extended
  word_t canon_nan;
  logic  a_lt_b;
  logic  new_sign;

  // ------------------------------
  // Operand classification
  // ------------------------------
  always_comb begin : classify
    if (fmt_i == FMT_FP16) begin
      sign_a    = op_a_i[HALF_BITS-1];
      sign_b    = op_b_i[HALF_BITS-1];
      mag_a     = word_t'(op_a_i[HALF_BITS-2:0]);
      mag_b     = word_t'(op_b_i[HALF_BITS-2:0]);
      nan_a     = (&op_a_i[HALF_BITS-2:MAN_H_BITS]) & (|op_a_i[MAN_H_BITS-1:0]);
      nan_b     = (&op_b_i[HALF_BITS-2:MAN_H_BITS]) & (|op_b_i[MAN_H_BITS-1:0]);
      snan_a    = nan_a & ~op_a_i[MAN_H_BITS-1]; // Quiet bit clear
      snan_b    = nan_b & ~op_b_i[MAN_H_BITS-1];
      canon_nan = CANON_NAN_H;
    end else begin
      sign_a    = op_a_i[WORD_BITS-1];
      sign_b    = op_b_i[WORD_BITS-1];
      mag_a     = {1'b0, op_a_i[WORD_BITS-2:0]};
      mag_b     = {1'b0, op_b_i[WORD_BITS-2:0]};
      nan_a     = (&op_a_i[WORD_BITS-2:MAN_S_BITS]) & (|op_a_i[MAN_S_BITS-1:0]);
      nan_b     = (&op_b_i[WORD_BITS-2:MAN_S_BITS]) & (|op_b_i[MAN_S_BITS-1:0]);
      snan_a    = nan_a & ~op_a_i[MAN_S_BITS-1];
      snan_b    = nan_b & ~op_b_i[MAN_S_BITS-1];
      canon_nan = CANON_NAN_S;
    end
    zero_a = (mag_a == '0);
    zero_b = (mag_b == '0);
  end

  // Sign-magnitude ordering
  always_comb begin : order
    if (zero_a && zero_b) a_lt_b = sign_a & ~sign_b; // -0 below +0
    else if (sign_a != sign_b) a_lt_b = sign_a;
    else if (sign_a) a_lt_b = (mag_a > mag_b);
    else a_lt_b = (mag_a < mag_b);
  end

  // Sign to inject for the SGNJ family
  always_comb begin : inject_sign
    case (op_i)
      OP_SGNJN: new_sign = ~sign_b;
      OP_SGNJX: new_sign = sign_a ^ sign_b;
      default:  new_sign = sign_b;
    endcase
  end

  // ------------------------------
  // Result select
  // ------------------------------
  always_comb begin : compute
    result_o = op_a_i;
    status_o = '0;
    if (op_i == OP_MIN || op_i == OP_MAX) begin
      status_o[NV_BIT] = snan_a | snan_b;
      if (nan_a && nan_b) result_o = canon_nan;
      else if (nan_a) result_o = op_b_i;
      else if (nan_b) result_o = op_a_i;
      else if ((op_i == OP_MIN) == a_lt_b) result_o = op_a_i;
      else result_o = op_b_i;
    end else if (fmt_i == FMT_FP16) begin
      result_o[HALF_BITS-1] = new_sign; // Keep a's magnitude
    end else begin
      result_o[WORD_BITS-1] = new_sign;
    end
  end

endmodule

`default_nettype wire

//--- hdl/fp_lane_pipe.sv
/*
 * Lane output pipeline of PIPE_STAGES enable registers.
 * Valid/ready handshake with back-pressure and synchronous flush.
 */
`default_nettype none

module fp_lane_pipe
  import fpslice_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    flush_i,
  input  logic    in_valid_i,
  output logic    in_ready_o,
  input  word_t   result_i,
  input  status_t status_i,
  input  logic    mask_i,
  input  tag_t    tag_i,
  input  fp_fmt_e fmt_i,
  input  logic    vector_i,
  input  logic    out_ready_i,
  output logic    out_valid_o,
  output word_t   result_o,
  output status_t status_o,
  output logic    mask_o,
  output tag_t    tag_o,
  output fp_fmt_e fmt_o,
  output logic    vector_o,
  output logic    busy_o
);

  // Index i holds the value after i register stages
  logic [0:PIPE_STAGES] valid_q;
  logic [0:PIPE_STAGES] ready;
  logic [0:PIPE_STAGES] mask_q;
  logic [0:PIPE_STAGES] vector_q;
  word_t                result_q [0:PIPE_STAGES];
  status_t              status_q [0:PIPE_STAGES];
  tag_t                 tag_q    [0:PIPE_STAGES];
  fp_fmt_e              fmt_q    [0:PIPE_STAGES];

  assign valid_q[0]  = in_valid_i;
  assign result_q[0] = result_i;
  assign status_q[0] = status_i;
  assign mask_q[0]   = mask_i;
  assign tag_q[0]    = tag_i;
  assign fmt_q[0]    = fmt_i;
  assign vector_q[0] = vector_i;

  for (genvar i = 0; i < int'(PIPE_STAGES); i++) begin : gen_stage
    logic load;

    // Advance when the next stage moves on or holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];
    assign load     = ready[i] & valid_q[i];

    always_ff @(posedge clk_i or negedge rst_n_i) begin : valid_reg
      if (!rst_n_i) valid_q[i+1] <= 1'b0;
      else if (flush_i) valid_q[i+1] <= 1'b0;
      else if (ready[i]) valid_q[i+1] <= valid_q[i];
    end

    always_ff @(posedge clk_i) begin : data_reg
      if (load) begin
        result_q[i+1] <= result_q[i];
        status_q[i+1] <= status_q[i];
        mask_q[i+1]   <= mask_q[i];
        tag_q[i+1]    <= tag_q[i];
        fmt_q[i+1]    <= fmt_q[i];
        vector_q[i+1] <= vector_q[i];
      end
    end
  end

  // Ready comes back from the sink
  assign ready[PIPE_STAGES] = out_ready_i;
  assign in_ready_o         = ready[0];

  assign out_valid_o = valid_q[PIPE_STAGES];
  assign result_o    = result_q[PIPE_STAGES];
  assign status_o    = status_q[PIPE_STAGES];
  assign mask_o      = mask_q[PIPE_STAGES];
  assign tag_o       = tag_q[PIPE_STAGES];
  assign fmt_o       = fmt_q[PIPE_STAGES];
  assign vector_o    = vector_q[PIPE_STAGES];
  assign busy_o      = |valid_q[1:PIPE_STAGES];

  // A stalled item stays at the output unchanged
  stall_holds_item: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i && !flush_i |=>
      out_valid_o && $stable(result_o) && $stable(status_o) && $stable(tag_o));

endmodule

`default_nettype wire

//--- hdl/fp_slice_lane.sv
/*
 * One SIMD lane. Slices the operands, applies the FP16 NaN-boxing check,
 * computes the operation and registers it in the lane pipeline.
 */
`default_nettype none

module fp_slice_lane
  import fpslice_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      flush_i,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  input  word_t     operand_a_i,
  input  word_t     operand_b_i,
  input  slice_op_e op_i,
  input  fp_fmt_e   fmt_i,
  input  logic      vectorial_op_i,
  input  logic      mask_i,
  input  tag_t      tag_i,
  input  logic      lane_upper_i,  // Tied per instance
  input  logic      out_ready_i,
  output logic      out_valid_o,
  output word_t     result_o,
  output status_t   status_o,
  output logic      mask_o,
  output tag_t      tag_o,
  output fp_fmt_e   fmt_o,
  output logic      vector_o,
  output logic      busy_o
);

  logic    is_vector;
  logic    in_valid;
  word_t   lane_a, lane_b;
  word_t   op_result;
  status_t op_status;

  assign is_vector = vectorial_op_i & (fmt_i == FMT_FP16);
  assign in_valid  = in_valid_i & (~lane_upper_i | is_vector); // Upper lane only for vectors

  always_comb begin : prepare_operands
    lane_a = lane_upper_i ? (operand_a_i >> HALF_BITS) : operand_a_i;
    lane_b = lane_upper_i ? (operand_b_i >> HALF_BITS) : operand_b_i;
    // Scalar FP16 operands must be NaN-boxed
    if (fmt_i == FMT_FP16 && !vectorial_op_i) begin
      if (operand_a_i[WORD_BITS-1:HALF_BITS] != '1) lane_a = CANON_NAN_H;
      if (operand_b_i[WORD_BITS-1:HALF_BITS] != '1) lane_b = CANON_NAN_H;
    end
  end

  fp_sgnj_minmax i_sgnj_minmax (
    .op_a_i   (lane_a),
    .op_b_i   (lane_b),
    .op_i     (op_i),
    .fmt_i    (fmt_i),
    .result_o (op_result),
    .status_o (op_status)
  );

  fp_lane_pipe i_lane_pipe (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready_o),
    .result_i    (op_result),
    .status_i    (op_status),
    .mask_i      (mask_i),
    .tag_i       (tag_i),
    .fmt_i       (fmt_i),
    .vector_i    (is_vector),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o),
    .result_o    (result_o),
    .status_o    (status_o),
    .mask_o      (mask_o),
    .tag_o       (tag_o),
    .fmt_o       (fmt_o),
    .vector_o    (vector_o),
    .busy_o      (busy_o)
  );

endmodule

`default_nettype wire

//--- hdl/fp_lane_merge.sv
/*
 * Output side of the slice. Gates the upper lane handshake, packs and
 * NaN-boxes the lane results and collapses the masked status flags.
 */
`default_nettype none

module fp_lane_merge
  import fpslice_pkg::*;
(
  input  lane_mask_t lane_valid_i,
  input  word_t      lane_result_0_i,
  input  word_t      lane_result_1_i,
  input  status_t    lane_status_0_i,
  input  status_t    lane_status_1_i,
  input  lane_mask_t lane_mask_i,
  input  fp_fmt_e    fmt_i,      // Format of the lane 0 item
  input  logic       vector_i,   // Lane 0 item is a vector
  input  logic       out_ready_i,
  output lane_mask_t lane_ready_o,
  output logic       out_valid_o,
  output word_t      result_o,
  output status_t    status_o
);

  lane_mask_t               lane_valid;
  logic [HALF_BITS-1:0]     upper_half;

  // Lane 1 only takes part in vector results
  assign lane_valid   = {lane_valid_i[1] & vector_i, lane_valid_i[0]};
  assign lane_ready_o = {out_ready_i & vector_i, out_ready_i};
  assign out_valid_o  = lane_valid[0];

  // ------------------------------
  // Result packing
  // ------------------------------
  // An idle upper lane leaves the NaN-box
  assign upper_half = lane_valid[1] ? lane_result_1_i[HALF_BITS-1:0] : '1;

  always_comb begin : pack_result
    if (fmt_i == FMT_FP32) begin
      result_o = lane_result_0_i;
    end else begin
      result_o = {upper_half, lane_result_0_i[HALF_BITS-1:0]};
    end
  end

  // ------------------------------
  // Status collapse
  // ------------------------------
  always_comb begin : collapse_status
    status_o = '0;
    if (lane_valid[0]) status_o |= lane_status_0_i & {STATUS_BITS{lane_mask_i[0]}};
    if (lane_valid[1]) status_o |= lane_status_1_i & {STATUS_BITS{lane_mask_i[1]}};
  end

endmodule

`default_nettype wire

//--- hdl/fp_noncomp_slice.sv
/*
 * FP non-computational slice with two SIMD lanes and a merge stage.
 * MIN/MAX and sign injection on FP32 or FP16 scalars and FP16 vectors.
 */
`default_nettype none

module fp_noncomp_slice
  import fpslice_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  word_t      operand_a_i,
  input  word_t      operand_b_i,
  input  slice_op_e  op_i,
  input  fp_fmt_e    fmt_i,
  input  logic       vectorial_op_i,
  input  tag_t       tag_i,
  input  lane_mask_t simd_mask_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  logic       flush_i,
  output word_t      result_o,
  output status_t    status_o,
  output tag_t       tag_o,
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output logic       busy_o
);

  lane_mask_t lane_in_valid, lane_in_ready;
  lane_mask_t lane_out_valid, lane_out_ready;
  lane_mask_t lane_masks, lane_vector, lane_busy;
  word_t      lane_result [NUM_LANES];
  status_t    lane_status [NUM_LANES];
  tag_t       lane_tag    [NUM_LANES];
  fp_fmt_e    lane_fmt    [NUM_LANES];

  // Lane 1 only loads together with lane 0 to stay in lockstep
  assign lane_in_valid = {in_valid_i & lane_in_ready[0], in_valid_i};
  assign in_ready_o    = lane_in_ready[0];

  for (genvar lane = 0; lane < int'(NUM_LANES); lane++) begin : gen_lanes
    fp_slice_lane i_lane (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .flush_i        (flush_i),
      .in_valid_i     (lane_in_valid[lane]),
      .in_ready_o     (lane_in_ready[lane]),
      .operand_a_i    (operand_a_i),
      .operand_b_i    (operand_b_i),
      .op_i           (op_i),
      .fmt_i          (fmt_i),
      .vectorial_op_i (vectorial_op_i),
      .mask_i         (simd_mask_i[lane]),
      .tag_i          (tag_i),
      .lane_upper_i   (lane != 0),
      .out_ready_i    (lane_out_ready[lane]),
      .out_valid_o    (lane_out_valid[lane]),
      .result_o       (lane_result[lane]),
      .status_o       (lane_status[lane]),
      .mask_o         (lane_masks[lane]),
      .tag_o          (lane_tag[lane]),
      .fmt_o          (lane_fmt[lane]),
      .vector_o       (lane_vector[lane]),
      .busy_o         (lane_busy[lane])
    );
  end

  fp_lane_merge i_merge (
    .lane_valid_i    (lane_out_valid),
    .lane_result_0_i (lane_result[0]),
    .lane_result_1_i (lane_result[1]),
    .lane_status_0_i (lane_status[0]),
    .lane_status_1_i (lane_status[1]),
    .lane_mask_i     (lane_masks),
    .fmt_i           (lane_fmt[0]),
    .vector_i        (lane_vector[0]),
    .out_ready_i     (out_ready_i),
    .lane_ready_o    (lane_out_ready),
    .out_valid_o     (out_valid_o),
    .result_o        (result_o),
    .status_o        (status_o)
  );

  assign tag_o  = lane_tag[0];   // Upper lane tag is a copy
  assign busy_o = |lane_busy;

  // A vector item enters both lanes on the same edge
  vector_accept_both: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in_valid_i && in_ready_o && vectorial_op_i && fmt_i == FMT_FP16 |-> lane_in_ready[1]);

  // Lane 1 presents the same vector item as lane 0
  vector_lanes_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lane_out_valid[0] && lane_vector[0] |->
      lane_out_valid[1] && lane_vector[1] && lane_fmt[1] == FMT_FP16 &&
      lane_tag[1] == lane_tag[0]);

endmodule

`default_nettype wire

//--- include/fp_ref_model.svh
/*
 * Reference model of the slice at bit level. FP16/FP32 min/max and sign
 * injection with NaN-boxing, vector packing and masked flags.
 */
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

// Single lane in one format
function automatic void ref_lane(input logic [31:0] a, input logic [31:0] b,
                                 input fpslice_pkg::slice_op_e op, input logic half,
                                 output logic [31:0] res, output logic nv);
  logic        sa, sb, na, nb, qa, qb, lt;
  logic [31:0] ma, mb;
  sa = half ? a[15] : a[31];
  sb = half ? b[15] : b[31];
  ma = half ? {17'b0, a[14:0]} : {1'b0, a[30:0]};
  mb = half ? {17'b0, b[14:0]} : {1'b0, b[30:0]};
  na = half ? ((&a[14:10]) && (|a[9:0])) : ((&a[30:23]) && (|a[22:0]));
  nb = half ? ((&b[14:10]) && (|b[9:0])) : ((&b[30:23]) && (|b[22:0]));
  qa = half ? a[9] : a[22];
  qb = half ? b[9] : b[22];
  lt = (sa != sb) ? sa : (sa ? (ma > mb) : (ma < mb));
  nv = 1'b0;
  res = a;
  if (op == fpslice_pkg::OP_MIN || op == fpslice_pkg::OP_MAX) begin
    nv = (na && !qa) || (nb && !qb);
    if (na && nb) res = half ? fpslice_pkg::CANON_NAN_H : fpslice_pkg::CANON_NAN_S;
    else if (na) res = b;
    else if (nb) res = a;
    else res = ((op == fpslice_pkg::OP_MIN) == lt) ? a : b;
  end else begin
    if (op == fpslice_pkg::OP_SGNJ) sa = sb;
    else if (op == fpslice_pkg::OP_SGNJN) sa = ~sb;
    else sa = sa ^ sb;
    if (half) res[15] = sa;
    else res[31] = sa;
  end
endfunction

// Whole slice result and status for one accepted item
function automatic void ref_slice(input logic [31:0] a, input logic [31:0] b,
                                  input fpslice_pkg::slice_op_e op,
                                  input fpslice_pkg::fp_fmt_e fmt,
                                  input logic vec, input logic [1:0] mask,
                                  output logic [31:0] res, output logic [4:0] status);
  logic [31:0] r0, r1, a0, b0;
  logic        nv0, nv1;
  logic        half;
  half = (fmt == fpslice_pkg::FMT_FP16);
  a0 = a;
  b0 = b;
  r1 = '1;
  nv1 = 1'b0;
  if (half && !vec) begin
    if (a[31:16] != 16'hffff) a0 = fpslice_pkg::CANON_NAN_H;
    if (b[31:16] != 16'hffff) b0 = fpslice_pkg::CANON_NAN_H;
  end
  ref_lane(a0, b0, op, half, r0, nv0);
  if (half && vec) ref_lane(a >> 16, b >> 16, op, 1'b1, r1, nv1);
  res = half ? {r1[15:0], r0[15:0]} : r0;
  status = {(nv0 & mask[0]) | (nv1 & mask[1]), 4'b0000};
endfunction

`endif

//--- tests/tb_fp_noncomp_slice.sv
/*
 * Testbench of the FP non-computational slice. Random FP16/FP32 items
 * against the reference model, checked by concurrent assertions.
 */
`default_nettype none

module tb_fp_noncomp_slice
  import fpslice_pkg::*;
();

  `include "fp_ref_model.svh"

  localparam int unsigned SEED       = 32'h0b99_9fd1;
  localparam int          ITEMS      = 600;
  localparam int          MAX_CYCLES = ITEMS * 4 + 1600; // Up to 4 cycles per item

  typedef struct packed {
    word_t   result;
    status_t status;
    tag_t    tag;
    logic    boxed;   // Scalar FP16 result
  } expect_t;

  logic       clk_i, rst_n_i, in_valid_i, in_ready_o, flush_i;
  logic       vectorial_op_i, out_valid_o, busy_o;
  logic       out_ready_i = 1'b1;
  word_t      operand_a_i, operand_b_i, result_o;
  slice_op_e  op_i;
  fp_fmt_e    fmt_i;
  tag_t       tag_i, tag_o;
  lane_mask_t simd_mask_i;
  status_t    status_o;

  expect_t exp_q [$];
  expect_t exp_head;
  logic    exp_valid   = 1'b0;
  logic    fixed_phase = 1'b0;  // out_ready_i held high
  logic    rand_ready  = 1'b0;
  logic    accept;
  int      errors  = 0;
  int      checked = 0;
  int      cycles  = 0;

  fp_noncomp_slice dut0 (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .op_i           (op_i),
    .fmt_i          (fmt_i),
    .vectorial_op_i (vectorial_op_i),
    .tag_i          (tag_i),
    .simd_mask_i    (simd_mask_i),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .flush_i        (flush_i),
    .result_o       (result_o),
    .status_o       (status_o),
    .tag_o          (tag_o),
    .out_valid_o    (out_valid_o),
    .out_ready_i    (out_ready_i),
    .busy_o         (busy_o)
  );

  assign accept = in_valid_i && in_ready_o;

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin : sink_ready
    out_ready_i <= rand_ready ? 1'($urandom) : 1'b1;
  end

  always @(posedge clk_i) begin : watchdog
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // ------------------------------
  // Expected items
  // ------------------------------
  // Inputs are stable at the falling edge, so the next transfer is known here
  always @(negedge clk_i) begin : track_items
    expect_t item;
    word_t   res;
    status_t st;
    exp_valid = (exp_q.size() != 0);
    if (exp_valid) exp_head = exp_q[0];  // Item at the output now
    if (rst_n_i) begin
      if (out_valid_o && out_ready_i && exp_valid) begin
        void'(exp_q.pop_front());
        checked++;
      end
      if (flush_i) begin
        exp_q.delete();
      end else if (accept) begin
        ref_slice(operand_a_i, operand_b_i, op_i, fmt_i, vectorial_op_i, simd_mask_i,
                  res, st);
        item.result = res;
        item.status = st;
        item.tag    = tag_i;
        item.boxed  = (fmt_i == FMT_FP16) && !vectorial_op_i;
        exp_q.push_back(item);
      end
    end
  end

  // ------------------------------
  // Assertions
  // ------------------------------
  out_expected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && out_ready_i |-> exp_valid)
    else begin
      errors++;
      $display("t=%0t output transfer with no item outstanding", $time);
    end

  result_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && out_ready_i && exp_valid |-> result_o == exp_head.result)
    else begin
      errors++;
      $display("CHECK FAILED t=%0t result_o got %h exp %h", $time,
               $sampled(result_o), exp_head.result);
    end

  status_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && out_ready_i && exp_valid |-> status_o == exp_head.status)
    else begin
      errors++;
      $display("CHECK FAILED t=%0t status_o got %b exp %b", $time,
               $sampled(status_o), exp_head.status);
    end

  tag_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && out_ready_i && exp_valid |-> tag_o == exp_head.tag)
    else begin
      errors++;
      $display("CHECK FAILED t=%0t tag_o got %h exp %h", $time, $sampled(tag_o), exp_head.tag);
    end

  // Scalar FP16 keeps the NaN-box even while stalled
  box_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && exp_valid && exp_head.boxed |-> result_o[31:16] == 16'hffff)
    else begin
      errors++;
      $display("CHECK FAILED t=%0t result_o[31:16] got %h exp ffff", $time,
               $sampled(result_o[31:16]));
    end

  latency_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fixed_phase |-> out_valid_o == $past(accept, PIPE_STAGES))
    else begin
      errors++;
      $display("CHECK FAILED t=%0t out_valid_o got %b exp %b", $time,
               $sampled(out_valid_o), $past(accept, PIPE_STAGES));
    end

  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i || $rose(rst_n_i) |-> !out_valid_o && !busy_o)
    else begin
      errors++;
      $display("t=%0t output valid or busy during or right after reset", $time);
    end

  flush_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !busy_o && !out_valid_o)
    else begin
      errors++;
      $display("t=%0t slice still busy one cycle after a flush", $time);
    end

  // ------------------------------
  // Stimulus
  // ------------------------------
  function automatic logic [15:0] rand_half();
    logic       s;
    logic [8:0] pl;
    s  = 1'($urandom);
    pl = 9'($urandom);
    case ($urandom % 6)
      0:       rand_half = {s, 5'h1f, 1'b1, pl};         // Quiet NaN
      1:       rand_half = {s, 5'h1f, 1'b0, pl | 9'h1};  // Signaling NaN
      2:       rand_half = {s, 15'h0};
      default: rand_half = 16'($urandom);
    endcase
  endfunction

  function automatic word_t rand_single();
    logic        s;
    logic [21:0] pl;
    s  = 1'($urandom);
    pl = 22'($urandom);
    case ($urandom % 6)
      0:       rand_single = {s, 8'hff, 1'b1, pl};
      1:       rand_single = {s, 8'hff, 1'b0, pl | 22'h1};
      2:       rand_single = {s, 31'h0};
      default: rand_single = $urandom;
    endcase
  endfunction

  function automatic word_t make_operand(input fp_fmt_e fmt, input logic vec);
    if (fmt == FMT_FP32) make_operand = rand_single();
    else if (vec) make_operand = {rand_half(), rand_half()};
    else if ($urandom % 5 == 0) make_operand = {16'($urandom), rand_half()}; // Unboxed
    else make_operand = {16'hffff, rand_half()};
  endfunction

  // Starts and ends on a rising edge
  task automatic send_random();
    fp_fmt_e fmt;
    logic    vec;
    fmt = fp_fmt_e'($urandom % 2);
    vec = 1'($urandom);
    in_valid_i     <= 1'b1;
    operand_a_i    <= make_operand(fmt, vec);
    operand_b_i    <= make_operand(fmt, vec);
    op_i           <= slice_op_e'($urandom % 5);
    fmt_i          <= fmt;
    vectorial_op_i <= vec;
    tag_i          <= tag_t'($urandom);
    simd_mask_i    <= lane_mask_t'($urandom);
    @(negedge clk_i);
    while (!in_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    in_valid_i <= 1'b0;
  endtask

  task automatic pulse_flush();
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
  endtask

  task automatic drain();
    @(negedge clk_i);
    while (busy_o) @(negedge clk_i);
  endtask

  initial begin : stimulus
    void'($urandom(SEED));
    rst_n_i        = 1'b0;
    in_valid_i     = 1'b0;
    flush_i        = 1'b0;
    operand_a_i    = '0;
    operand_b_i    = '0;
    op_i           = OP_MIN;
    fmt_i          = FMT_FP32;
    vectorial_op_i = 1'b0;
    tag_i          = '0;
    simd_mask_i    = '0;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (2) @(posedge clk_i);

    fixed_phase <= 1'b1;  // Back-to-back with the sink always ready
    repeat (150) send_random();
    drain();
    @(posedge clk_i);
    fixed_phase <= 1'b0;
    rand_ready  <= 1'b1;
    repeat (300) begin
      send_random();
      if ($urandom % 4 == 0) @(posedge clk_i);
    end
    repeat (150) begin
      send_random();
      if ($urandom % 8 == 0) pulse_flush();
    end
    rand_ready <= 1'b0;
    drain();

    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected items never left the slice", exp_q.size());
    end
    $display("Items checked: %0d, errors: %0d", checked, errors);
    if (errors == 0) $display("Simulation completed successfully");
    else $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
hdl/fpslice_pkg.sv
hdl/fp_sgnj_minmax.sv
hdl/fp_lane_pipe.sv
hdl/fp_slice_lane.sv
hdl/fp_lane_merge.sv
hdl/fp_noncomp_slice.sv
tests/tb_fp_noncomp_slice.sv

//--- Makefile
# Verilator flow for the FP non-computational slice

TOP := tb_fp_noncomp_slice

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f verilog.f --top-module fp_noncomp_slice

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
